//--- bp_defines.svh
/*
 * Size macros for the branch prediction unit.
 * Included by the package and by any RTL module that sizes storage from them.
 */
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Number of entries in the bimodal counter table.
`define BP_TABLE_DEPTH 64

// Table index width, taken from PC bits starting at bit 2.
`define BP_INDEX_W 6

// Width of each performance counter; 64 is also supported.
`define BP_COUNT_W 32

`endif

//--- bp_pkg.sv
/*
 * Shared types for the branch prediction unit.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

`include "bp_defines.svh"

package bp_pkg;

    typedef logic [31:0] pc_t;                       // Program counter.
    typedef logic [12:0] imm_sb_t;                   // SB-type branch immediate.
    typedef logic [`BP_INDEX_W-1:0] bp_index_t;      // Predictor table index.
    typedef logic [1:0] sat_ctr_t;                   // Upper bit is the taken prediction.
    typedef logic [`BP_COUNT_W-1:0] stat_count_t;    // One performance counter.

    // Statistics in counter order; code 15 is unused and reads as zero.
    typedef enum logic [3:0] {
        STAT_PREDICTIONS,
        STAT_MISPREDICTIONS,
        STAT_CORRECT,
        STAT_PRED_TAKEN,
        STAT_PRED_NOT_TAKEN,
        STAT_TAKEN_INCORRECT,
        STAT_NOT_TAKEN_INCORRECT,
        STAT_FWD_BRANCHES,
        STAT_FWD_PRED_TAKEN,
        STAT_FWD_TAKEN_CORRECT,
        STAT_FWD_NOT_TAKEN_CORRECT,
        STAT_BWD_BRANCHES,
        STAT_BWD_PRED_TAKEN,
        STAT_BWD_TAKEN_CORRECT,
        STAT_BWD_NOT_TAKEN_CORRECT
    } stat_sel_e;

endpackage

`default_nettype wire

//--- bimodal_predictor.sv
/*
 * Bimodal direction predictor built from 2-bit saturating counters.
 * Fetch looks up combinationally; execute trains it once per resolved branch.
 */
`default_nettype none

`include "bp_defines.svh"

module bimodal_predictor
    import bp_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  pc_t  lookup_pc,
    output logic predict_taken,
    input  logic update_predictor,
    input  pc_t  update_pc,
    input  logic branch_result
);

    sat_ctr_t  ctr_table [`BP_TABLE_DEPTH];
    bp_index_t lookup_idx;
    bp_index_t update_idx;
    sat_ctr_t  update_ctr;
    sat_ctr_t  next_ctr;

    // Word aligned PCs, so the two low bits carry no information.
    assign lookup_idx = lookup_pc[`BP_INDEX_W+1:2];
    assign update_idx = update_pc[`BP_INDEX_W+1:2];

    assign predict_taken = ctr_table[lookup_idx][1];    // Upper bit gives the direction.
    assign update_ctr    = ctr_table[update_idx];

    // Count toward 11 on taken and toward 00 on not taken, holding at either end.
    always_comb begin
        next_ctr = update_ctr;
        if (branch_result) begin
            if (update_ctr != 2'b11) begin
                next_ctr = update_ctr + 2'b01;
            end
        end else begin
            if (update_ctr != 2'b00) begin
                next_ctr = update_ctr - 2'b01;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `BP_TABLE_DEPTH; i++) begin
                ctr_table[i] <= 2'b01;                  // Start weakly not taken.
            end
        end else if (update_predictor) begin
            ctr_table[update_idx] <= next_ctr;
        end
    end

endmodule

`default_nettype wire

//--- branch_tracker.sv
/*
 * Branch prediction performance counters, one per statistic in stat_sel_e.
 * Each resolved branch is classified by prediction, outcome and direction.
 */
`default_nettype none

module branch_tracker
    import bp_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  logic               update_predictor,
    input  logic               prediction,
    input  logic               branch_result,
    input  imm_sb_t            imm_sb,
    input  logic               counters_clear,
    output stat_count_t [14:0] stat_counts
);

    logic [14:0] inc;
    logic        backward;
    logic        correct;

    assign backward = imm_sb[12];                       // Negative offset jumps back.
    assign correct  = (prediction == branch_result);

    // One bit per counter that this branch advances.
    always_comb begin
        inc = '0;
        if (update_predictor) begin
            inc[STAT_PREDICTIONS]         = 1'b1;
            inc[STAT_MISPREDICTIONS]      = !correct;
            inc[STAT_CORRECT]             = correct;
            inc[STAT_PRED_TAKEN]          = prediction;
            inc[STAT_PRED_NOT_TAKEN]      = !prediction;
            inc[STAT_TAKEN_INCORRECT]     = prediction && !correct;
            inc[STAT_NOT_TAKEN_INCORRECT] = !prediction && !correct;

            // Direction split of the totals above.
            if (backward) begin
                inc[STAT_BWD_BRANCHES]          = 1'b1;
                inc[STAT_BWD_PRED_TAKEN]        = prediction;
                inc[STAT_BWD_TAKEN_CORRECT]     = prediction && correct;
                inc[STAT_BWD_NOT_TAKEN_CORRECT] = !prediction && correct;
            end else begin
                inc[STAT_FWD_BRANCHES]          = 1'b1;
                inc[STAT_FWD_PRED_TAKEN]        = prediction;
                inc[STAT_FWD_TAKEN_CORRECT]     = prediction && correct;
                inc[STAT_FWD_NOT_TAKEN_CORRECT] = !prediction && correct;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stat_counts <= '0;
        end else if (counters_clear) begin
            stat_counts <= '0;                          // Clear wins over a same cycle update.
        end else begin
            for (int i = 0; i < 15; i++) begin
                if (inc[i]) begin
                    stat_counts[i] <= stat_counts[i] + 1'b1;    // Wraps at full width.
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- stats_regs.sv
/*
 * Debug access to the performance counters.
 * Registers one selected counter per read strobe and delays the clear strobe.
 */
`default_nettype none

module stats_regs
    import bp_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  logic               stat_rd,
    input  logic               stat_clear,
    input  stat_sel_e          stat_sel,
    input  stat_count_t [14:0] stat_counts,
    output stat_count_t        stat_data,
    output logic               stat_valid,
    output logic               counters_clear
);

    stat_count_t sel_value;

    // Code 15 has no counter behind it.
    always_comb begin
        if (stat_sel > STAT_BWD_NOT_TAKEN_CORRECT) begin
            sel_value = '0;
        end else begin
            sel_value = stat_counts[stat_sel];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stat_data      <= '0;
            stat_valid     <= 1'b0;
            counters_clear <= 1'b0;
        end else begin
            stat_valid     <= stat_rd;                  // One cycle pulse per read.
            counters_clear <= stat_clear;               // Clear lands one edge later.
            if (stat_rd) begin
                stat_data <= sel_value;                 // Value before this edge's update.
            end
        end
    end

endmodule

`default_nettype wire

//--- branch_predict_unit.sv
/*
 * Branch prediction unit top level.
 * Connects the bimodal predictor, the performance tracker and its debug registers.
 */
`default_nettype none

module branch_predict_unit
    import bp_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  pc_t         lookup_pc,
    output logic        predict_taken,
    input  logic        update_predictor,
    input  pc_t         update_pc,
    input  imm_sb_t     imm_sb,
    input  logic        prediction,
    input  logic        branch_result,
    input  logic        stat_rd,
    input  stat_sel_e   stat_sel,
    input  logic        stat_clear,
    output stat_count_t stat_data,
    output logic        stat_valid
);

    stat_count_t [14:0] stat_counts;
    logic               counters_clear;

    bimodal_predictor u_predictor (
        .CLK              (CLK),
        .nRST             (nRST),
        .lookup_pc        (lookup_pc),
        .predict_taken    (predict_taken),
        .update_predictor (update_predictor),
        .update_pc        (update_pc),
        .branch_result    (branch_result)
    );

    branch_tracker u_tracker (
        .CLK              (CLK),
        .nRST             (nRST),
        .update_predictor (update_predictor),
        .prediction       (prediction),
        .branch_result    (branch_result),
        .imm_sb           (imm_sb),
        .counters_clear   (counters_clear),
        .stat_counts      (stat_counts)
    );

    stats_regs u_stats (
        .CLK              (CLK),
        .nRST             (nRST),
        .stat_rd          (stat_rd),
        .stat_clear       (stat_clear),
        .stat_sel         (stat_sel),
        .stat_counts      (stat_counts),
        .stat_data        (stat_data),
        .stat_valid       (stat_valid),
        .counters_clear   (counters_clear)
    );

endmodule

`default_nettype wire

//--- branch_predict_unit_checker.sv
/*
 * Concurrent assertions on the performance counters and the debug read timing.
 * Bound into stats_regs, which sees the tracker's counters and the read strobe.
 */
`default_nettype none

module branch_predict_unit_checker
    import bp_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  stat_count_t [14:0] stat_counts,
    input  logic               stat_rd,
    input  logic               stat_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Every branch is either forward or backward.
    assert property (@(posedge CLK) disable iff (!nRST)
        stat_counts[STAT_PREDICTIONS] ==
        stat_count_t'(stat_counts[STAT_FWD_BRANCHES] + stat_counts[STAT_BWD_BRANCHES]))
        else $error("Total branches differ from forward plus backward.");

    assert property (@(posedge CLK) disable iff (!nRST)
        stat_counts[STAT_PREDICTIONS] ==
        stat_count_t'(stat_counts[STAT_PRED_TAKEN] + stat_counts[STAT_PRED_NOT_TAKEN]))
        else $error("Total branches differ from taken plus not-taken predictions.");

    assert property (@(posedge CLK) disable iff (!nRST)
        stat_counts[STAT_PREDICTIONS] ==
        stat_count_t'(stat_counts[STAT_CORRECT] + stat_counts[STAT_MISPREDICTIONS]))
        else $error("Total branches differ from correct plus mispredicted.");

    // The read data is valid exactly one cycle after the strobe.
    assert property (@(posedge CLK) disable iff (!nRST) stat_rd |=> stat_valid)
        else $error("stat_valid missing one cycle after stat_rd.");

    assert property (@(posedge CLK) disable iff (!nRST) !stat_rd |=> !stat_valid)
        else $error("stat_valid high without a preceding stat_rd.");

endmodule

bind stats_regs branch_predict_unit_checker u_checker (
    .CLK         (CLK),
    .nRST        (nRST),
    .stat_counts (stat_counts),
    .stat_rd     (stat_rd),
    .stat_valid  (stat_valid)
);

`default_nettype wire

//--- branch_predict_unit_tb.sv
/*
 * Testbench for the branch prediction unit.
 * A reference model tracks the predictor table and the statistics and is compared each cycle.
 */
`default_nettype none

`include "bp_defines.svh"

module branch_predict_unit_tb
    import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 4000;

    logic        CLK = 1'b0;
    logic        nRST;
    pc_t         lookup_pc;
    logic        predict_taken;
    logic        update_predictor;
    pc_t         update_pc;
    imm_sb_t     imm_sb;
    logic        prediction;
    logic        branch_result;
    logic        stat_rd;
    stat_sel_e   stat_sel;
    logic        stat_clear;
    stat_count_t stat_data;
    logic        stat_valid;

    sat_ctr_t    ref_table [`BP_TABLE_DEPTH];
    stat_count_t ref_stats [15];
    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    int          updates_sent = 0;
    logic        read_pending = 1'b0;
    stat_count_t read_expect = '0;
    logic        clear_pending = 1'b0;
    logic        clear_now;

    branch_predict_unit u_dut (.*);

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual=0x%0h expected=0x%0h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    // Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};       // One step per bit taken.
        end
        return v;
    endfunction

    function automatic logic expected_taken(input pc_t pc);
        return ref_table[pc[`BP_INDEX_W+1:2]][1];
    endfunction

    function automatic void bump_stat(input stat_sel_e s);
        ref_stats[s] = ref_stats[s] + stat_count_t'(1);
    endfunction

    // Advances the model by one clock edge.
    function automatic void reference_step(input logic upd, input pc_t pc, input imm_sb_t imm,
                                           input logic pred, input logic res, input logic clr);
        bp_index_t idx;
        idx = pc[`BP_INDEX_W+1:2];
        if (upd && res && ref_table[idx] != 2'b11) ref_table[idx] = ref_table[idx] + 2'b01;
        if (upd && !res && ref_table[idx] != 2'b00) ref_table[idx] = ref_table[idx] - 2'b01;
        if (clr) begin
            for (int i = 0; i < 15; i++) ref_stats[i] = '0;
        end else if (upd) begin
            bump_stat(STAT_PREDICTIONS);
            bump_stat(pred ? STAT_PRED_TAKEN : STAT_PRED_NOT_TAKEN);
            if (pred == res) bump_stat(STAT_CORRECT);
            else bump_stat(STAT_MISPREDICTIONS);
            if (pred != res) bump_stat(pred ? STAT_TAKEN_INCORRECT : STAT_NOT_TAKEN_INCORRECT);
            if (imm[12]) begin
                bump_stat(STAT_BWD_BRANCHES);
                if (pred) bump_stat(STAT_BWD_PRED_TAKEN);
                if (pred == res) begin
                    bump_stat(pred ? STAT_BWD_TAKEN_CORRECT : STAT_BWD_NOT_TAKEN_CORRECT);
                end
            end else begin
                bump_stat(STAT_FWD_BRANCHES);
                if (pred) bump_stat(STAT_FWD_PRED_TAKEN);
                if (pred == res) begin
                    bump_stat(pred ? STAT_FWD_TAKEN_CORRECT : STAT_FWD_NOT_TAKEN_CORRECT);
                end
            end
        end
    endfunction

    // Compares at each rising edge before the model takes this edge's inputs.
    always @(posedge CLK) begin
        if (nRST) begin
            check_value("predict_taken", predict_taken, expected_taken(lookup_pc));
            check_value("stat_valid", stat_valid, read_pending);
            if (read_pending) check_value("stat_data", stat_data, read_expect);
            read_pending = stat_rd;
            if (stat_rd) read_expect = (stat_sel == 4'd15) ? '0 : ref_stats[stat_sel];
            clear_now = clear_pending;
            clear_pending = stat_clear;          // Clear reaches the counters one edge later.
            reference_step(update_predictor, update_pc, imm_sb, prediction, branch_result,
                           clear_now);
        end
    end

    task automatic send_update(input pc_t pc, input imm_sb_t imm, input logic pred,
                               input logic res);
        update_predictor = 1'b1;
        update_pc = pc;
        imm_sb = imm;
        prediction = pred;
        branch_result = res;
        updates_sent = updates_sent + 1;
        @(negedge CLK);
        update_predictor = 1'b0;
    endtask

    task automatic read_stat(input logic [3:0] code, output stat_count_t value);
        stat_sel = stat_sel_e'(code);
        stat_rd = 1'b1;
        @(negedge CLK);
        stat_rd = 1'b0;
        check_value("stat_valid", stat_valid, 1'b1);   // Fixed one cycle latency.
        value = stat_data;
    endtask

    task automatic sweep_lookup(input logic expect_low);
        for (int i = 0; i < `BP_TABLE_DEPTH; i++) begin
            lookup_pc = pc_t'(i) << 2;
            @(negedge CLK);
            if (expect_low) check_value("predict_taken", predict_taken, 1'b0);
        end
    endtask

    initial begin
        pc_t         upc;
        stat_count_t value;
        nRST = 1'b0;
        lookup_pc = '0;
        update_predictor = 1'b0;
        update_pc = '0;
        imm_sb = '0;
        prediction = 1'b0;
        branch_result = 1'b0;
        stat_rd = 1'b0;
        stat_sel = STAT_PREDICTIONS;
        stat_clear = 1'b0;
        lfsr_state = 16'd24753;
        for (int i = 0; i < `BP_TABLE_DEPTH; i++) ref_table[i] = 2'b01;
        for (int i = 0; i < 15; i++) ref_stats[i] = '0;
        repeat (8) @(negedge CLK);
        nRST = 1'b1;

        for (int s = 0; s < 15; s++) begin
            read_stat(4'(s), value);
            check_value("stat_data", value, 0);
        end
        sweep_lookup(1'b1);

        // Two taken updates move 01 to 11, three not-taken ones bring it to 00.
        lookup_pc = 32'h0000_1234;
        send_update(32'h0000_1234, 13'h0010, 1'b0, 1'b1);
        send_update(32'h0000_1234, 13'h0010, 1'b0, 1'b1);
        check_value("predict_taken", predict_taken, 1'b1);
        lookup_pc = 32'h0000_1238;
        @(negedge CLK);
        check_value("predict_taken", predict_taken, 1'b0);
        lookup_pc = 32'h0000_1234;
        repeat (3) send_update(32'h0000_1234, 13'h1ff0, 1'b1, 1'b0);
        check_value("predict_taken", predict_taken, 1'b0);

        for (int n = 0; n < 300; n++) begin
            upc = pc_t'(rand_bits(30)) << 2;
            if (rand_bits(1) != 0) lookup_pc = upc;
            else lookup_pc = pc_t'(rand_bits(30)) << 2;
            send_update(upc, imm_sb_t'(rand_bits(12)) << 1, rand_bits(1) != 0,
                        rand_bits(1) != 0);
            if (rand_bits(2) == 0) @(negedge CLK);  // Idle cycle now and then.
        end
        for (int s = 0; s < 16; s++) read_stat(4'(s), value);

        read_stat(STAT_PREDICTIONS, value);
        check_value("stat_data", value, updates_sent);
        read_stat(4'd15, value);
        check_value("stat_data", value, 0);

        // An update right after the clear is dropped, one two cycles later counts.
        stat_clear = 1'b1;
        @(negedge CLK);
        stat_clear = 1'b0;
        send_update(32'h0000_0040, 13'h0020, 1'b1, 1'b1);
        for (int s = 0; s < 15; s++) begin
            read_stat(4'(s), value);
            check_value("stat_data", value, 0);
        end
        stat_clear = 1'b1;
        @(negedge CLK);
        stat_clear = 1'b0;
        @(negedge CLK);
        send_update(32'h0000_0080, 13'h1fe0, 1'b1, 1'b1);
        read_stat(STAT_PREDICTIONS, value);
        check_value("stat_data", value, 1);
        read_stat(STAT_BWD_TAKEN_CORRECT, value);
        check_value("stat_data", value, 1);
        sweep_lookup(1'b0);

        repeat (3) @(negedge CLK);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- branch_predict_unit.f
+incdir+.
bp_pkg.sv
bimodal_predictor.sv
branch_tracker.sv
stats_regs.sv
branch_predict_unit.sv
branch_predict_unit_checker.sv
branch_predict_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the branch prediction unit testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the testbench stops on $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f branch_predict_unit.f --top-module branch_predict_unit_tb -o branch_predict_unit_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/branch_predict_unit_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "Simulation failed with status $run_status"
    exit "$run_status"
fi
exit 0
